//--- source/timer_defs.svh
`ifndef TIMER_DEFS_SVH
`define TIMER_DEFS_SVH

////////////////////////////////////////
// time arithmetic constants
////////////////////////////////////////

`define SECS_PER_MIN   60
`define SECS_PER_HOUR  3600
`define SECS_PER_DAY   86400

// one field is two bcd digits
`define BCD_W          8

// enough for 0 .. SECS_PER_DAY-1
`define SECS_W         17

`endif

//--- source/timer_pkg.sv
`include "timer_defs.svh"

package timer_pkg;

    // hh:mm:ss as three bcd fields, hour in the top byte
    typedef struct packed {
        logic [`BCD_W-1:0] hour;
        logic [`BCD_W-1:0] min;
        logic [`BCD_W-1:0] sec;
    } bcd_time_t;

    // seconds since midnight
    typedef logic [`SECS_W-1:0] secs_t;

    typedef enum logic [2:0] {
        idle         = 3'd0,
        setting      = 3'd1,
        counting     = 3'd2,
        ringing      = 3'd3,
        wait_release = 3'd4
    } timer_state_e;

endpackage

//--- source/countdown_if.sv
`timescale 1ns/1ps

// countdown result, arithmetic stage to encoder
interface countdown_if;
    timer_pkg::secs_t remaining;
    logic             active;
    logic             ring;
    // one cycle pulse when remaining is written
    logic             update;

    modport source
    (
        output remaining,
        output active,
        output ring,
        output update
    );

    modport sink
    (
        input remaining,
        input active,
        input ring,
        input update
    );
endinterface

//--- source/bcd_time_decode.sv
`timescale 1ns/1ps
`include "timer_defs.svh"

module bcd_time_decode
(
    input  logic                 clk,
    input  logic                 reset,
    input  timer_pkg::bcd_time_t time_in,
    output timer_pkg::secs_t     secs,
    output logic                 valid
);

    logic [6:0]       hour_bin;
    logic [6:0]       min_bin;
    logic [6:0]       sec_bin;
    logic             fields_ok;
    timer_pkg::secs_t secs_next;

    function automatic logic [6:0] bcd_to_bin(input logic [`BCD_W-1:0] bcd);
        bcd_to_bin = 7'(bcd[7:4]) * 7'd10 + 7'(bcd[3:0]);
    endfunction

    // tens digit limited per field, units always 0..9
    function automatic logic digits_ok(input logic [`BCD_W-1:0] bcd, input logic [3:0] max_tens);
        digits_ok = (bcd[7:4] <= max_tens) && (bcd[3:0] <= 4'd9);
    endfunction

    always_comb
    begin
        hour_bin  = bcd_to_bin(time_in.hour);
        min_bin   = bcd_to_bin(time_in.min);
        sec_bin   = bcd_to_bin(time_in.sec);
        fields_ok = digits_ok(time_in.hour, 4'd2) && (hour_bin <= 7'd23)
                 && digits_ok(time_in.min, 4'd5)
                 && digits_ok(time_in.sec, 4'd5);
        secs_next = `SECS_W'(hour_bin) * `SECS_W'(`SECS_PER_HOUR)
                  + `SECS_W'(min_bin) * `SECS_W'(`SECS_PER_MIN)
                  + `SECS_W'(sec_bin);
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            valid <= 1'b0;
        else
            valid <= fields_ok;
    end

    always_ff @(posedge clk)
    begin
        secs <= secs_next;
    end

    // a valid sample is always a time of day
    assert property (@(posedge clk) disable iff (reset)
        valid |-> (secs < `SECS_W'(`SECS_PER_DAY)));

endmodule

//--- source/countdown_core.sv
`timescale 1ns/1ps
`include "timer_defs.svh"

module countdown_core
(
    input  logic             clk,
    input  logic             reset,
    input  logic             sw_timer,
    input  logic             sw_ring,
    input  timer_pkg::secs_t now_secs,
    input  logic             now_valid,
    input  timer_pkg::secs_t set_secs,
    input  logic             set_valid,
    countdown_if.source      result
);

    timer_pkg::timer_state_e state;
    timer_pkg::timer_state_e state_next;

    timer_pkg::secs_t duration;
    timer_pkg::secs_t duration_next;
    timer_pkg::secs_t start;
    timer_pkg::secs_t start_next;
    timer_pkg::secs_t remaining_next;
    logic             update_next;

    timer_pkg::secs_t diff;
    timer_pkg::secs_t elapsed;
    timer_pkg::secs_t left;

    ////////////////////////////////////////
    // remaining time arithmetic
    ////////////////////////////////////////

    // wraps past midnight, result stays below one day
    always_comb
    begin
        diff    = now_secs - start;
        elapsed = (now_secs >= start) ? diff : diff + `SECS_W'(`SECS_PER_DAY);
        left    = (elapsed >= duration) ? '0 : duration - elapsed;
    end

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////

    always_comb
    begin
        state_next     = state;
        duration_next  = duration;
        start_next     = start;
        remaining_next = result.remaining;
        update_next    = 1'b0;

        if (sw_timer && state != timer_pkg::ringing)
        begin
            state_next = timer_pkg::setting;
            if (set_valid)
            begin
                duration_next  = set_secs;
                remaining_next = set_secs;
                update_next    = 1'b1;
            end
            else if (state != timer_pkg::setting)
            begin
                // new press starts from zero until a valid set time shows up
                duration_next  = '0;
                remaining_next = '0;
                update_next    = 1'b1;
            end
        end
        else
        begin
            case (state)
                timer_pkg::setting:
                begin
                    // switch released, arm on the current clock time
                    if (duration != '0 && now_valid)
                    begin
                        state_next = timer_pkg::counting;
                        start_next = now_secs;
                    end
                    else
                    begin
                        state_next     = timer_pkg::idle;
                        remaining_next = '0;
                        update_next    = 1'b1;
                    end
                end
                timer_pkg::counting:
                begin
                    if (now_valid)
                    begin
                        remaining_next = left;
                        update_next    = 1'b1;
                        if (left == '0)
                            state_next = timer_pkg::ringing;
                    end
                end
                timer_pkg::ringing:
                begin
                    if (sw_ring)
                        state_next = timer_pkg::wait_release;
                end
                timer_pkg::wait_release:
                begin
                    if (!sw_ring)
                        state_next = timer_pkg::idle;
                end
                timer_pkg::idle:
                begin
                    state_next = timer_pkg::idle;
                end
                default:
                begin
                    state_next = timer_pkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state            <= timer_pkg::idle;
            result.remaining <= '0;
            result.update    <= 1'b0;
            result.active    <= 1'b0;
            result.ring      <= 1'b0;
        end
        else
        begin
            state            <= state_next;
            result.remaining <= remaining_next;
            result.update    <= update_next;
            result.active    <= (state_next == timer_pkg::counting);
            result.ring      <= (state_next == timer_pkg::ringing);
        end
    end

    always_ff @(posedge clk)
    begin
        duration <= duration_next;
        start    <= start_next;
    end

    // ring only with the timer stopped and the count at zero
    assert property (@(posedge clk) disable iff (reset)
        result.ring |-> (!result.active && result.remaining == '0));

    // countdown never shows more than was set
    assert property (@(posedge clk) disable iff (reset)
        (state == timer_pkg::counting) |-> (result.remaining <= duration));

endmodule

//--- source/bcd_time_encode.sv
`timescale 1ns/1ps
`include "timer_defs.svh"

module bcd_time_encode
(
    input  logic                 clk,
    input  logic                 reset,
    countdown_if.sink            result,
    output timer_pkg::bcd_time_t remain,
    output logic                 active,
    output logic                 ring
);

    timer_pkg::secs_t     hour_part;
    timer_pkg::secs_t     below_hour;
    timer_pkg::secs_t     min_part;
    timer_pkg::secs_t     sec_part;
    timer_pkg::bcd_time_t remain_next;

    // 0..99 to two bcd digits
    function automatic logic [`BCD_W-1:0] bin_to_bcd(input logic [6:0] value);
        bin_to_bcd = {4'(value / 7'd10), 4'(value % 7'd10)};
    endfunction

    always_comb
    begin
        hour_part        = result.remaining / `SECS_W'(`SECS_PER_HOUR);
        below_hour       = result.remaining % `SECS_W'(`SECS_PER_HOUR);
        min_part         = below_hour / `SECS_W'(`SECS_PER_MIN);
        sec_part         = below_hour % `SECS_W'(`SECS_PER_MIN);
        remain_next.hour = bin_to_bcd(7'(hour_part));
        remain_next.min  = bin_to_bcd(7'(min_part));
        remain_next.sec  = bin_to_bcd(7'(sec_part));
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            remain <= '0;
            active <= 1'b0;
            ring   <= 1'b0;
        end
        else
        begin
            // display holds between updates
            if (result.update)
                remain <= remain_next;
            active <= result.active;
            ring   <= result.ring;
        end
    end

endmodule

//--- source/countdown_timer_top.sv
`timescale 1ns/1ps
`include "timer_defs.svh"

module countdown_timer_top
(
    input  logic              clk,
    input  logic              reset,
    input  logic              sw_timer,
    input  logic              sw_ring,
    input  logic [`BCD_W-1:0] rtc_hour,
    input  logic [`BCD_W-1:0] rtc_min,
    input  logic [`BCD_W-1:0] rtc_sec,
    input  logic [`BCD_W-1:0] set_hour,
    input  logic [`BCD_W-1:0] set_min,
    input  logic [`BCD_W-1:0] set_sec,
    output logic [`BCD_W-1:0] remain_hour,
    output logic [`BCD_W-1:0] remain_min,
    output logic [`BCD_W-1:0] remain_sec,
    output logic              timer_active,
    output logic              ring
);

    timer_pkg::bcd_time_t rtc_time;
    timer_pkg::bcd_time_t set_time;
    timer_pkg::bcd_time_t remain;
    timer_pkg::secs_t     now_secs;
    logic                 now_valid;
    timer_pkg::secs_t     set_secs;
    logic                 set_valid;

    countdown_if result_if();

    assign rtc_time = '{hour: rtc_hour, min: rtc_min, sec: rtc_sec};
    assign set_time = '{hour: set_hour, min: set_min, sec: set_sec};

    assign remain_hour = remain.hour;
    assign remain_min  = remain.min;
    assign remain_sec  = remain.sec;

    ////////////////////////////////////////
    // decode, countdown, encode
    ////////////////////////////////////////

    bcd_time_decode rtc_decode (.clk(clk), .reset(reset), .time_in(rtc_time),
                                .secs(now_secs), .valid(now_valid));

    bcd_time_decode set_decode (.clk(clk), .reset(reset), .time_in(set_time),
                                .secs(set_secs), .valid(set_valid));

    countdown_core core (.clk(clk), .reset(reset), .sw_timer(sw_timer), .sw_ring(sw_ring),
                         .now_secs(now_secs), .now_valid(now_valid),
                         .set_secs(set_secs), .set_valid(set_valid),
                         .result(result_if.source));

    bcd_time_encode encode (.clk(clk), .reset(reset), .result(result_if.sink),
                            .remain(remain), .active(timer_active), .ring(ring));

endmodule

//--- tb/tb_countdown_timer.sv
`timescale 1ns/1ps
`include "timer_defs.svh"

module tb_countdown_timer;

    localparam int clk_period      = 40;
    localparam int reset_cycles    = 5;
    localparam int num_runs        = 8;
    localparam int run_limit       = 300;
    localparam int total_cycles    = reset_cycles + 80 + num_runs * (run_limit + 40) + 60;
    localparam int watchdog_cycles = total_cycles + total_cycles / 4;

    localparam int st_idle         = 0;
    localparam int st_setting      = 1;
    localparam int st_counting     = 2;
    localparam int st_ringing      = 3;
    localparam int st_wait_release = 4;

    logic                 clk;
    logic                 reset;
    logic                 sw_timer;
    logic                 sw_ring;
    timer_pkg::bcd_time_t rtc_time;
    timer_pkg::bcd_time_t set_time;
    logic [`BCD_W-1:0]    remain_hour;
    logic [`BCD_W-1:0]    remain_min;
    logic [`BCD_W-1:0]    remain_sec;
    logic                 timer_active;
    logic                 ring;
    timer_pkg::bcd_time_t dut_remain;

    integer seed;
    int     clock_secs;
    int     cycle_count;
    int     garbled_count;

    // model state, one group per pipeline stage
    int                   d_now_secs;
    int                   d_set_secs;
    bit                   d_now_valid;
    bit                   d_set_valid;
    int                   c_state;
    int                   c_duration;
    int                   c_start;
    int                   c_remaining;
    bit                   c_update;
    bit                   c_active;
    bit                   c_ring;
    timer_pkg::bcd_time_t e_remain;
    logic                 e_active;
    logic                 e_ring;

    countdown_timer_top DUT
    (
        .clk(clk),
        .reset(reset),
        .sw_timer(sw_timer),
        .sw_ring(sw_ring),
        .rtc_hour(rtc_time.hour),
        .rtc_min(rtc_time.min),
        .rtc_sec(rtc_time.sec),
        .set_hour(set_time.hour),
        .set_min(set_time.min),
        .set_sec(set_time.sec),
        .remain_hour(remain_hour),
        .remain_min(remain_min),
        .remain_sec(remain_sec),
        .timer_active(timer_active),
        .ring(ring)
    );

    assign dut_remain = {remain_hour, remain_min, remain_sec};

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial
    begin
        #(watchdog_cycles * clk_period);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        abort_run();
    end

    ////////////////////////////////////////
    // time conversions and random helpers
    ////////////////////////////////////////

    function automatic int rand_below(input int n);
        rand_below = int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [`BCD_W-1:0] to_bcd(input int value);
        to_bcd = {4'(value / 10), 4'(value % 10)};
    endfunction

    function automatic timer_pkg::bcd_time_t secs_to_bcd(input int secs);
        timer_pkg::bcd_time_t t;
        t.hour = to_bcd(secs / `SECS_PER_HOUR);
        t.min  = to_bcd((secs % `SECS_PER_HOUR) / `SECS_PER_MIN);
        t.sec  = to_bcd(secs % `SECS_PER_MIN);
        secs_to_bcd = t;
    endfunction

    function automatic int field_value(input logic [`BCD_W-1:0] f);
        field_value = int'(f[7:4]) * 10 + int'(f[3:0]);
    endfunction

    function automatic bit field_ok(input logic [`BCD_W-1:0] f, input int max_value);
        field_ok = (f[7:4] <= 4'd9) && (f[3:0] <= 4'd9) && (field_value(f) <= max_value);
    endfunction

    function automatic bit time_valid(input timer_pkg::bcd_time_t t);
        time_valid = field_ok(t.hour, 23) && field_ok(t.min, 59) && field_ok(t.sec, 59);
    endfunction

    function automatic int time_secs(input timer_pkg::bcd_time_t t);
        time_secs = field_value(t.hour) * `SECS_PER_HOUR + field_value(t.min) * `SECS_PER_MIN
                  + field_value(t.sec);
    endfunction

    // out of range hour or minute, or a non-decimal digit
    function automatic timer_pkg::bcd_time_t garble_time(input timer_pkg::bcd_time_t t);
        case (rand_below(4))
            0:       t.hour = 8'h24 + 8'(rand_below(6));
            1:       t.min  = 8'h60 + 8'(rand_below(10));
            2:       t.sec  = {4'(rand_below(6)), 4'ha + 4'(rand_below(6))};
            default: t.hour = {4'ha + 4'(rand_below(6)), 4'h0};
        endcase
        garble_time = t;
    endfunction

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    task automatic reset_model;
        d_now_valid = 1'b0;
        d_set_valid = 1'b0;
        d_now_secs  = 0;
        d_set_secs  = 0;
        c_state     = st_idle;
        c_duration  = 0;
        c_start     = 0;
        c_remaining = 0;
        c_update    = 1'b0;
        c_active    = 1'b0;
        c_ring      = 1'b0;
        e_remain    = '0;
        e_active    = 1'b0;
        e_ring      = 1'b0;
    endtask

    // one clock edge, last stage first so each reads the old values
    task automatic advance_model;
        int elapsed;
        int left;
        if (c_update)
            e_remain = secs_to_bcd(c_remaining);
        e_active = c_active;
        e_ring   = c_ring;

        c_update = 1'b0;
        if (sw_timer && c_state != st_ringing)
        begin
            if (d_set_valid)
            begin
                c_duration  = d_set_secs;
                c_remaining = d_set_secs;
                c_update    = 1'b1;
            end
            else if (c_state != st_setting)
            begin
                c_duration  = 0;
                c_remaining = 0;
                c_update    = 1'b1;
            end
            c_state = st_setting;
        end
        else
        begin
            case (c_state)
                st_setting:
                begin
                    if (c_duration != 0 && d_now_valid)
                    begin
                        c_state = st_counting;
                        c_start = d_now_secs;
                    end
                    else
                    begin
                        c_state     = st_idle;
                        c_remaining = 0;
                        c_update    = 1'b1;
                    end
                end
                st_counting:
                begin
                    if (d_now_valid)
                    begin
                        elapsed     = (d_now_secs - c_start + `SECS_PER_DAY) % `SECS_PER_DAY;
                        left        = (elapsed >= c_duration) ? 0 : c_duration - elapsed;
                        c_remaining = left;
                        c_update    = 1'b1;
                        if (left == 0)
                            c_state = st_ringing;
                    end
                end
                st_ringing:
                begin
                    if (sw_ring)
                        c_state = st_wait_release;
                end
                st_wait_release:
                begin
                    if (!sw_ring)
                        c_state = st_idle;
                end
                default:
                begin
                    c_state = st_idle;
                end
            endcase
        end
        c_active = (c_state == st_counting);
        c_ring   = (c_state == st_ringing);

        d_now_valid = time_valid(rtc_time);
        d_now_secs  = time_secs(rtc_time);
        d_set_valid = time_valid(set_time);
        d_set_secs  = time_secs(set_time);
    endtask

    ////////////////////////////////////////
    // checks and stepping
    ////////////////////////////////////////

    task automatic abort_run;
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_remain(input timer_pkg::bcd_time_t actual,
                                input timer_pkg::bcd_time_t expected);
        if (actual !== expected)
        begin
            $display("Error: remain_hour/min/sec is %h, expected %h (cycle %0d)",
                     actual, expected, cycle_count);
            abort_run();
        end
    endtask

    task automatic check_flags(input logic active_got, input logic ring_got,
                               input logic active_exp, input logic ring_exp);
        if (active_got !== active_exp)
        begin
            $display("Error: timer_active is %h, expected %h (cycle %0d)",
                     active_got, active_exp, cycle_count);
            abort_run();
        end
        if (ring_got !== ring_exp)
        begin
            $display("Error: ring is %h, expected %h (cycle %0d)", ring_got, ring_exp, cycle_count);
            abort_run();
        end
    endtask

    // inputs change 2 ns after the edge, outputs are read at 1 ns
    task automatic step;
        @(posedge clk);
        #1;
        advance_model();
        check_remain(dut_remain, e_remain);
        check_flags(timer_active, ring, e_active, e_ring);
        cycle_count++;
        #1;
    endtask

    // set time is applied before the press so the decoder has it ready
    task automatic try_rejected_arm(input timer_pkg::bcd_time_t set_value, input bit rtc_ok);
        set_time = set_value;
        rtc_time = secs_to_bcd(clock_secs);
        if (!rtc_ok)
            rtc_time = garble_time(rtc_time);
        repeat (2) step();
        sw_timer = 1'b1;
        repeat (4) step();
        sw_timer = 1'b0;
        repeat (5) step();
        check_flags(timer_active, ring, 1'b0, 1'b0);
        check_remain(dut_remain, '0);
        rtc_time = secs_to_bcd(clock_secs);
    endtask

    task automatic countdown_run(input int run);
        int dur;
        int step_max;
        int spent;
        int advance;
        int waited;
        dur = (run % 3 == 2) ? 1 + rand_below(20 * `SECS_PER_HOUR) : 1 + rand_below(300);
        // odd runs start just before midnight
        if (run % 2 == 1)
            clock_secs = `SECS_PER_DAY - 1 - rand_below(dur);
        else
            clock_secs = rand_below(`SECS_PER_DAY);
        rtc_time = secs_to_bcd(clock_secs);
        set_time = secs_to_bcd(dur);
        repeat (2) step();
        sw_timer = 1'b1;
        repeat (4) step();
        sw_timer = 1'b0;

        step_max = dur / 40 + 2;
        spent    = 0;
        waited   = 0;
        while (!ring)
        begin
            if (waited == run_limit)
            begin
                $display("countdown run %0d never rang within %0d cycles", run, run_limit);
                abort_run();
            end
            // now and then jump to just past zero
            if (waited > 10 && spent < dur && rand_below(16) == 0)
                advance = dur - spent + rand_below(3);
            else
                advance = rand_below(step_max);
            spent      = spent + advance;
            clock_secs = clock_secs + advance;
            if (clock_secs >= `SECS_PER_DAY)
                clock_secs = clock_secs - `SECS_PER_DAY;
            rtc_time = secs_to_bcd(clock_secs);
            if (rand_below(8) == 0)
            begin
                rtc_time = garble_time(rtc_time);
                garbled_count++;
            end
            step();
            waited++;
        end

        // a press while ringing is ignored
        sw_timer = 1'b1;
        repeat (2) step();
        sw_timer = 1'b0;
        repeat (3) step();
        sw_ring = 1'b1;
        waited  = 0;
        while (ring)
        begin
            if (waited == 10)
            begin
                $display("ring stayed high after sw_ring was raised in run %0d", run);
                abort_run();
            end
            step();
            waited++;
        end
        repeat (2) step();
        sw_ring = 1'b0;
        repeat (3) step();
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial
    begin
        seed          = 67;
        cycle_count   = 0;
        garbled_count = 0;
        clock_secs    = 0;
        reset         = 1'b1;
        sw_timer      = 1'b0;
        sw_ring       = 1'b0;
        rtc_time      = secs_to_bcd(0);
        set_time      = '0;
        reset_model();
        repeat (reset_cycles) @(posedge clk);
        #2;
        reset = 1'b0;
        check_remain(dut_remain, '0);
        check_flags(timer_active, ring, 1'b0, 1'b0);

        // switch held, set time wanders
        sw_timer = 1'b1;
        repeat (40)
        begin
            clock_secs = (clock_secs + rand_below(3)) % `SECS_PER_DAY;
            rtc_time   = secs_to_bcd(clock_secs);
            set_time   = secs_to_bcd(rand_below(`SECS_PER_DAY));
            if (rand_below(6) == 0)
                set_time = garble_time(set_time);
            step();
        end
        try_rejected_arm(secs_to_bcd(0), 1'b1);

        for (int run = 0; run < num_runs; run++)
            countdown_run(run);

        try_rejected_arm(garble_time(secs_to_bcd(1 + rand_below(3600))), 1'b1);
        try_rejected_arm(secs_to_bcd(1 + rand_below(3600)), 1'b0);

        if (garbled_count > 0)
        begin
            $display("TEST PASS");
            $finish;
        end
        else
        begin
            $display("stimulus never sent an invalid clock sample while counting");
            abort_run();
        end
    end

endmodule

//--- compile.f
+incdir+source
source/timer_pkg.sv
source/countdown_if.sv
source/bcd_time_decode.sv
source/countdown_core.sv
source/bcd_time_encode.sv
source/countdown_timer_top.sv
tb/tb_countdown_timer.sv

//--- Makefile
TOP = tb_countdown_timer

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f compile.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir
